//--- Bender.yml
package:
  name: wired_lsu_sb

sources:
  - files:
      - design/wired_sb_pkg.sv
      - design/wired_lsu_sb_entry.sv
      - design/wired_lsu_sb.sv
      - design/wired_lsu_sb_fwd.sv
      - design/wired_lsu_sb_drain.sv
      - design/wired_lsu_sb_top.sv
  - target: test
    files:
      - tests/wired_lsu_sb_assert.sv
      - tests/wired_lsu_sb_tb.sv

//--- design/wired_lsu_sb.sv
// store buffer control with fifo pointers, occupancy flags and the entry array
`timescale 1ns/1ns

module wired_lsu_sb (
  input  logic                                                  clk,
  input  logic                                                  rst_n_i,
  input  logic                                                  flush_i,
  input  logic                                                  valid_i,
  input  wired_sb_pkg::sb_meta_t                                meta_i,
  output logic                                                  ready_o,
  input  logic                                                  pop_i,
  input  wired_sb_pkg::dsram_snoop_t                            snoop_i,
  output logic [wired_sb_pkg::SB_DEPTH-1:0]                     valid_o,
  output wired_sb_pkg::sb_meta_t [wired_sb_pkg::SB_DEPTH-1:0]   meta_o,
  output logic [wired_sb_pkg::SB_PTR_W-1:0]                     top_o
);

  logic [wired_sb_pkg::SB_CNT_W-1:0] cnt_q;
  // write pointer at next free slot, read pointer at oldest store
  logic [wired_sb_pkg::SB_PTR_W-1:0] w_ptr_q;
  logic [wired_sb_pkg::SB_PTR_W-1:0] r_ptr_q;
  logic                              empty_q;
  logic                              full_q;
  logic                              pop;

  // ignore a stray pop on an empty buffer
  assign pop = pop_i && !empty_q;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      w_ptr_q <= '0;
      r_ptr_q <= '0;
      cnt_q   <= '0;
      empty_q <= 1'b1;
      full_q  <= 1'b0;
    end
    else if (flush_i)
    begin
      w_ptr_q <= '0;
      r_ptr_q <= '0;
      cnt_q   <= '0;
      empty_q <= 1'b1;
      full_q  <= 1'b0;
    end
    else
    begin
      case ({valid_i, pop})
        2'b11:
        begin
          // count unchanged
          w_ptr_q <= w_ptr_q + 1'b1;
          r_ptr_q <= r_ptr_q + 1'b1;
        end
        2'b10:
        begin
          w_ptr_q <= w_ptr_q + 1'b1;
          cnt_q   <= cnt_q + 1'b1;
          empty_q <= 1'b0;
          full_q  <= (cnt_q == wired_sb_pkg::SB_CNT_W'(wired_sb_pkg::SB_DEPTH - 1));
        end
        2'b01:
        begin
          r_ptr_q <= r_ptr_q + 1'b1;
          cnt_q   <= cnt_q - 1'b1;
          empty_q <= (cnt_q == wired_sb_pkg::SB_CNT_W'(1));
          full_q  <= 1'b0;
        end
        default:
        begin
        end
      endcase
    end
  end

  // per-slot write and invalidate strobes
  for (genvar i = 0; i < wired_sb_pkg::SB_DEPTH; i++)
  begin : g_entry
    logic wr;
    logic inv;

    // flush beats a store arriving in the same cycle
    assign wr  = valid_i && !flush_i && (w_ptr_q == wired_sb_pkg::SB_PTR_W'(i));
    assign inv = flush_i || (pop && (r_ptr_q == wired_sb_pkg::SB_PTR_W'(i)));

    wired_lsu_sb_entry u_entry (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .invalid_i (inv),
      .valid_i   (wr),
      .meta_i    (meta_i),
      .snoop_i   (snoop_i),
      .valid_o   (valid_o[i]),
      .meta_o    (meta_o[i])
    );
  end

  assign top_o   = r_ptr_q;
  assign ready_o = !full_q;

endmodule

//--- design/wired_lsu_sb_drain.sv
// commit credit counter and sram write issue for the oldest buffered store
`timescale 1ns/1ns

module wired_lsu_sb_drain (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    flush_i,
  input  logic                    commit_i,
  input  logic                    top_valid_i,
  input  wired_sb_pkg::sb_meta_t  top_meta_i,
  output logic                    pop_o,
  output logic                    dsram_we_o,
  output wired_sb_pkg::dsram_wr_t dsram_wr_o
);

  // committed stores still waiting to be written
  logic [wired_sb_pkg::SB_CNT_W-1:0] credit_q;
  logic                              fire;

  // a committed miss stalls here until a snoop sets hit
  assign fire = top_valid_i && top_meta_i.hit && (credit_q != '0);

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      credit_q <= '0;
    end
    else if (flush_i)
    begin
      credit_q <= '0;
    end
    else
    begin
      // commit and drain together leave the credit unchanged
      case ({commit_i, fire})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  assign pop_o      = fire;
  assign dsram_we_o = fire;

  // index above the word offset, both from the word address
  always_comb
  begin
    dsram_wr_o.idx  = top_meta_i.addr[wired_sb_pkg::IDX_W+wired_sb_pkg::OFS_W-1:
                                      wired_sb_pkg::OFS_W];
    dsram_wr_o.ofs  = top_meta_i.addr[wired_sb_pkg::OFS_W-1:0];
    dsram_wr_o.way  = top_meta_i.way;
    dsram_wr_o.data = top_meta_i.data;
    dsram_wr_o.strb = top_meta_i.strb;
  end

endmodule

//--- design/wired_lsu_sb_entry.sv
// single store buffer entry with valid bit, metadata register and snoop update
`timescale 1ns/1ns

module wired_lsu_sb_entry (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       invalid_i,
  input  logic                       valid_i,
  input  wired_sb_pkg::sb_meta_t     meta_i,
  input  wired_sb_pkg::dsram_snoop_t snoop_i,
  output logic                       valid_o,
  output wired_sb_pkg::sb_meta_t     meta_o
);

  logic                   valid_q;
  wired_sb_pkg::sb_meta_t meta_q;
  wired_sb_pkg::sb_meta_t meta_d;
  logic                   snoop_hit;

  // write wins, only collides with invalidate on push and pop while full
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      valid_q <= 1'b0;
    end
    else if (valid_i)
    begin
      valid_q <= 1'b1;
    end
    else if (invalid_i)
    begin
      valid_q <= 1'b0;
    end
  end

  // new store or held store, snoop applies on top of either
  always_comb
  begin
    meta_d = meta_q;
    if (valid_i)
    begin
      meta_d = meta_i;
    end
    snoop_hit = snoop_i.valid && (valid_i || valid_q) &&
                (snoop_i.line == meta_d.addr[wired_sb_pkg::ADDR_W-1:wired_sb_pkg::OFS_W]);
    if (snoop_hit)
    begin
      meta_d.hit = 1'b1;
      meta_d.way = snoop_i.way;
    end
  end

  always_ff @(posedge clk)
  begin
    meta_q <= meta_d;
  end

  assign valid_o = valid_q;
  assign meta_o  = meta_q;

endmodule

//--- design/wired_lsu_sb_fwd.sv
// byte-wise store to load forwarding across all entries, youngest store wins
`timescale 1ns/1ns

module wired_lsu_sb_fwd (
  input  logic [wired_sb_pkg::SB_DEPTH-1:0]                   valid_i,
  input  wired_sb_pkg::sb_meta_t [wired_sb_pkg::SB_DEPTH-1:0] meta_i,
  input  logic [wired_sb_pkg::SB_PTR_W-1:0]                   top_i,
  input  logic [wired_sb_pkg::ADDR_W-1:0]                     ld_addr_i,
  output logic [31:0]                                         fwd_data_o,
  output logic [3:0]                                          fwd_strb_o
);

  // per-entry word address match, in slot order
  logic [wired_sb_pkg::SB_DEPTH-1:0] addr_match;

  always_comb
  begin
    for (int e = 0; e < wired_sb_pkg::SB_DEPTH; e++)
    begin
      addr_match[e] = valid_i[e] && (meta_i[e].addr == ld_addr_i);
    end
  end

  // oldest first so every later match overwrites the byte
  always_comb
  begin : p_merge
    logic [wired_sb_pkg::SB_PTR_W-1:0] slot;

    fwd_data_o = '0;
    fwd_strb_o = '0;
    for (int k = 0; k < wired_sb_pkg::SB_DEPTH; k++)
    begin
      // pointer arithmetic wraps around the ring
      slot = top_i + wired_sb_pkg::SB_PTR_W'(k);
      if (addr_match[slot])
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (meta_i[slot].strb[b])
          begin
            fwd_data_o[8*b +: 8] = meta_i[slot].data[8*b +: 8];
            fwd_strb_o[b]        = 1'b1;
          end
        end
      end
    end
  end

endmodule

//--- design/wired_lsu_sb_top.sv
// store buffer top with entry array, load forwarding and sram drain
`timescale 1ns/1ns

module wired_lsu_sb_top (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              flush_i,
  input  logic                              st_valid_i,
  input  wired_sb_pkg::sb_meta_t            st_meta_i,
  output logic                              st_ready_o,
  input  logic                              commit_i,
  input  wired_sb_pkg::dsram_snoop_t        snoop_i,
  input  logic [wired_sb_pkg::ADDR_W-1:0]   ld_addr_i,
  output logic [31:0]                       ld_fwd_data_o,
  output logic [3:0]                        ld_fwd_strb_o,
  output logic                              dsram_we_o,
  output wired_sb_pkg::dsram_wr_t           dsram_wr_o
);

  logic [wired_sb_pkg::SB_DEPTH-1:0]                   sb_valid;
  wired_sb_pkg::sb_meta_t [wired_sb_pkg::SB_DEPTH-1:0] sb_meta;
  logic [wired_sb_pkg::SB_PTR_W-1:0]                   sb_top;
  logic                                                sb_pop;
  logic                                                top_valid;
  wired_sb_pkg::sb_meta_t                              top_meta;

  wired_lsu_sb u_sb (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (st_valid_i),
    .meta_i  (st_meta_i),
    .ready_o (st_ready_o),
    .pop_i   (sb_pop),
    .snoop_i (snoop_i),
    .valid_o (sb_valid),
    .meta_o  (sb_meta),
    .top_o   (sb_top)
  );

  wired_lsu_sb_fwd u_fwd (
    .valid_i    (sb_valid),
    .meta_i     (sb_meta),
    .top_i      (sb_top),
    .ld_addr_i  (ld_addr_i),
    .fwd_data_o (ld_fwd_data_o),
    .fwd_strb_o (ld_fwd_strb_o)
  );

  // oldest entry goes to the drain
  assign top_valid = sb_valid[sb_top];
  assign top_meta  = sb_meta[sb_top];

  wired_lsu_sb_drain u_drain (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .commit_i    (commit_i),
    .top_valid_i (top_valid),
    .top_meta_i  (top_meta),
    .pop_o       (sb_pop),
    .dsram_we_o  (dsram_we_o),
    .dsram_wr_o  (dsram_wr_o)
  );

endmodule

//--- design/wired_sb_pkg.sv
// store buffer depth, address widths and packed store, snoop and sram write types
package wired_sb_pkg;

  // buffer geometry
  localparam int unsigned SB_DEPTH = 4;
  localparam int unsigned SB_PTR_W = 2;
  // occupancy and credit counters must reach SB_DEPTH itself
  localparam int unsigned SB_CNT_W = SB_PTR_W + 1;

  // word address, two low bits pick the word inside a 16-byte line
  localparam int unsigned ADDR_W = 30;
  localparam int unsigned OFS_W  = 2;
  localparam int unsigned LINE_W = ADDR_W - OFS_W;

  // line index sits right above the word offset
  localparam int unsigned IDX_W = 8;
  localparam int unsigned WAY_W = 2;

  // one pending store as seen by the buffer
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [31:0]       data;
    logic [3:0]        strb;
    // line is present in the cache
    logic              hit;
    logic [WAY_W-1:0]  way;
  } sb_meta_t;

  // refill landing in the data sram, level valid
  typedef struct packed {
    logic              valid;
    logic [LINE_W-1:0] line;
    logic [WAY_W-1:0]  way;
  } dsram_snoop_t;

  // word write into the data sram
  typedef struct packed {
    logic [IDX_W-1:0] idx;
    logic [OFS_W-1:0] ofs;
    logic [WAY_W-1:0] way;
    logic [31:0]      data;
    logic [3:0]       strb;
  } dsram_wr_t;

endpackage

//--- tests/wired_lsu_sb_assert.sv
// bound assertions on store buffer push, occupancy and flush recovery
`timescale 1ns/1ns

module wired_lsu_sb_assert (
  input logic                              clk,
  input logic                              rst_n_i,
  input logic                              flush_i,
  input logic                              valid_i,
  input logic                              ready_i,
  input logic [wired_sb_pkg::SB_CNT_W-1:0] cnt_i
);

  int unsigned fail_cnt = 0;

  // caller must hold off while the buffer is full
  a_no_push_full : assert property (
    @(posedge clk) disable iff (!rst_n_i) valid_i |-> ready_i
  )
  else
  begin
    fail_cnt++;
    $error("store accepted while the buffer was full");
  end

  a_cnt_range : assert property (
    @(posedge clk) disable iff (!rst_n_i) cnt_i <= wired_sb_pkg::SB_DEPTH
  )
  else
  begin
    fail_cnt++;
    $error("occupancy count above buffer depth");
  end

  // flush empties the buffer in one edge
  a_ready_after_flush : assert property (
    @(posedge clk) disable iff (!rst_n_i) flush_i |=> ready_i
  )
  else
  begin
    fail_cnt++;
    $error("buffer not ready in the cycle after a flush");
  end

endmodule

bind wired_lsu_sb wired_lsu_sb_assert u_assert (
  .clk     (clk),
  .rst_n_i (rst_n_i),
  .flush_i (flush_i),
  .valid_i (valid_i),
  .ready_i (ready_o),
  .cnt_i   (cnt_q)
);

//--- tests/wired_lsu_sb_tb.sv
// store buffer testbench with stimulus table, lockstep reference model and sram image
`timescale 1ns/1ns

module wired_lsu_sb_tb;

  typedef enum {OP_STORE, OP_COMMIT, OP_SNOOP, OP_LOAD, OP_FLUSH, OP_IDLE,
                OP_READY, OP_WAIT_READY, OP_WAIT_WR, OP_NO_WR, OP_MEM} op_e;

  typedef struct {
    string                           name;
    op_e                             op;
    logic [wired_sb_pkg::ADDR_W-1:0] addr;
    logic [3:0]                      strb;
    logic                            hit;
    logic [wired_sb_pkg::WAY_W-1:0]  way;
    int                              exp;
  } step_t;

  logic                            clk;
  logic                            rst_n_i;
  logic                            flush_i;
  logic                            st_valid_i;
  wired_sb_pkg::sb_meta_t          st_meta_i;
  logic                            st_ready_o;
  logic                            commit_i;
  wired_sb_pkg::dsram_snoop_t      snoop_i;
  logic [wired_sb_pkg::ADDR_W-1:0] ld_addr_i;
  logic [31:0]                     ld_fwd_data_o;
  logic [3:0]                      ld_fwd_strb_o;
  logic                            dsram_we_o;
  wired_sb_pkg::dsram_wr_t         dsram_wr_o;

  step_t                           steps[$];
  string                           cur_step;
  // reference model with the oldest store at the front
  wired_sb_pkg::sb_meta_t          model_q[$];
  int                              credit;
  logic [31:0]                     shadow_mem[4096];
  logic [31:0]                     dut_mem[4096];

  wired_lsu_sb_top dut_i (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .st_valid_i    (st_valid_i),
    .st_meta_i     (st_meta_i),
    .st_ready_o    (st_ready_o),
    .commit_i      (commit_i),
    .snoop_i       (snoop_i),
    .ld_addr_i     (ld_addr_i),
    .ld_fwd_data_o (ld_fwd_data_o),
    .ld_fwd_strb_o (ld_fwd_strb_o),
    .dsram_we_o    (dsram_we_o),
    .dsram_wr_o    (dsram_wr_o)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    if (act !== exp)
    begin
      $display("Fail %s: expected %0h, actual %0h", what, exp, act);
      stop_run();
    end
  endtask

  // way above line index and word offset from the low ten address bits
  function automatic logic [11:0] sram_key(input logic [29:0] addr, input logic [1:0] way);
    return {way, addr[9:0]};
  endfunction

  function automatic void add_step(input string name, input op_e op, input logic [29:0] addr,
                                   input logic [3:0] strb, input logic hit,
                                   input logic [1:0] way, input int exp);
    step_t s;

    s.name = name;
    s.op   = op;
    s.addr = addr;
    s.strb = strb;
    s.hit  = hit;
    s.way  = way;
    s.exp  = exp;
    steps.push_back(s);
  endfunction

  // model follows the DUT one cycle at a time on the stable negedge
  always @(negedge clk)
  begin : model_step
    logic                    fire;
    logic [11:0]             key;
    logic [31:0]             fdata;
    logic [3:0]              fstrb;
    wired_sb_pkg::sb_meta_t  ent;
    wired_sb_pkg::dsram_wr_t exp_wr;

    if (!rst_n_i)
    begin
      model_q.delete();
      credit = 0;
    end
    else
    begin
      fire = (model_q.size() != 0) && model_q[0].hit && (credit != 0);
      check_value({cur_step, " ready"}, model_q.size() != wired_sb_pkg::SB_DEPTH, st_ready_o);
      check_value({cur_step, " write enable"}, fire, dsram_we_o);
      if (fire)
      begin
        ent         = model_q[0];
        exp_wr.idx  = ent.addr[9:2];
        exp_wr.ofs  = ent.addr[1:0];
        exp_wr.way  = ent.way;
        exp_wr.data = ent.data;
        exp_wr.strb = ent.strb;
        check_value({cur_step, " write command"}, exp_wr, dsram_wr_o);
        key = sram_key(ent.addr, ent.way);
        for (int b = 0; b < 4; b++)
        begin
          if (ent.strb[b])
          begin
            shadow_mem[key][8*b +: 8] = ent.data[8*b +: 8];
          end
        end
      end
      // sram image as the DUT writes it
      if (dsram_we_o)
      begin
        key = {dsram_wr_o.way, dsram_wr_o.idx, dsram_wr_o.ofs};
        for (int b = 0; b < 4; b++)
        begin
          if (dsram_wr_o.strb[b])
          begin
            dut_mem[key][8*b +: 8] = dsram_wr_o.data[8*b +: 8];
          end
        end
      end
      // youngest store wins each byte
      fdata = '0;
      fstrb = '0;
      foreach (model_q[k])
      begin
        if (model_q[k].addr == ld_addr_i)
        begin
          for (int b = 0; b < 4; b++)
          begin
            if (model_q[k].strb[b])
            begin
              fdata[8*b +: 8] = model_q[k].data[8*b +: 8];
              fstrb[b]        = 1'b1;
            end
          end
        end
      end
      check_value({cur_step, " fwd data"}, fdata, ld_fwd_data_o);
      check_value({cur_step, " fwd strb"}, fstrb, ld_fwd_strb_o);
      if (flush_i)
      begin
        model_q.delete();
        credit = 0;
      end
      else
      begin
        if (fire)
        begin
          void'(model_q.pop_front());
        end
        if (st_valid_i && st_ready_o)
        begin
          model_q.push_back(st_meta_i);
        end
        // refill also covers the store written at this edge
        if (snoop_i.valid)
        begin
          foreach (model_q[k])
          begin
            ent = model_q[k];
            if (ent.addr[29:2] == snoop_i.line)
            begin
              ent.hit    = 1'b1;
              ent.way    = snoop_i.way;
              model_q[k] = ent;
            end
          end
        end
        credit = credit + int'(commit_i) - int'(fire);
      end
    end
  end

  task automatic wait_ready(input string what);
    int n;

    n = 0;
    @(negedge clk);
    while (!st_ready_o)
    begin
      n++;
      if (n > 50)
      begin
        $display("%s: st_ready_o stayed low for 50 cycles", what);
        stop_run();
      end
      @(negedge clk);
    end
  endtask

  task automatic wait_write(input string what);
    int n;

    n = 0;
    @(negedge clk);
    while (!dsram_we_o)
    begin
      n++;
      if (n > 50)
      begin
        $display("%s: no SRAM write arrived within 50 cycles", what);
        stop_run();
      end
      @(negedge clk);
    end
  endtask

  task automatic run_step(input step_t s);
    wired_sb_pkg::sb_meta_t     meta;
    wired_sb_pkg::dsram_snoop_t snp;

    cur_step = s.name;
    case (s.op)
      OP_STORE:
      begin
        wait_ready(s.name);
        meta.addr = s.addr;
        meta.data = $urandom();
        meta.strb = (s.strb != 4'h0) ? s.strb : 4'($urandom_range(15, 1));
        meta.hit  = s.hit;
        meta.way  = s.way;
        @(posedge clk);
        st_valid_i <= 1'b1;
        st_meta_i  <= meta;
        @(posedge clk);
        st_valid_i <= 1'b0;
      end
      OP_COMMIT:
      begin
        @(posedge clk);
        commit_i <= 1'b1;
        @(posedge clk);
        commit_i <= 1'b0;
      end
      OP_FLUSH:
      begin
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
      end
      OP_SNOOP:
      begin
        snp.valid = 1'b1;
        snp.line  = s.addr[29:2];
        snp.way   = s.way;
        @(posedge clk);
        snoop_i <= snp;
        @(posedge clk);
        snoop_i <= '0;
      end
      OP_LOAD:
      begin
        @(posedge clk);
        ld_addr_i <= s.addr;
        @(negedge clk);
        check_value(s.name, s.exp, ld_fwd_strb_o);
      end
      OP_READY:
      begin
        @(negedge clk);
        check_value(s.name, s.exp, st_ready_o);
      end
      OP_WAIT_READY:
      begin
        wait_ready(s.name);
      end
      OP_WAIT_WR:
      begin
        wait_write(s.name);
      end
      OP_NO_WR:
      begin
        repeat (s.exp)
        begin
          @(negedge clk);
          check_value(s.name, 0, dsram_we_o);
        end
      end
      OP_MEM:
      begin
        @(posedge clk);
        check_value(s.name, shadow_mem[sram_key(s.addr, s.way)],
                    dut_mem[sram_key(s.addr, s.way)]);
      end
      default:
      begin
        repeat (s.exp) @(posedge clk);
      end
    endcase
  endtask

  // strobe 0 in a store step means random strobes
  function automatic void build_table();
    add_step("ready after reset", OP_READY, 30'h0, 4'h0, 1'b0, 2'd0, 1);
    add_step("fill 0", OP_STORE, 30'h0000100, 4'h0, 1'b1, 2'd1, 0);
    add_step("fill 1", OP_STORE, 30'h0000101, 4'h0, 1'b1, 2'd1, 0);
    add_step("fill 2", OP_STORE, 30'h0000102, 4'h0, 1'b1, 2'd1, 0);
    add_step("fill 3", OP_STORE, 30'h0000103, 4'h0, 1'b1, 2'd1, 0);
    add_step("full after four stores", OP_READY, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("commit fill 0", OP_COMMIT, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("ready after one drain", OP_WAIT_READY, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("commit fill 1", OP_COMMIT, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("drain fill 1", OP_WAIT_WR, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("commit fill 2", OP_COMMIT, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("drain fill 2", OP_WAIT_WR, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("commit fill 3", OP_COMMIT, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("drain fill 3", OP_WAIT_WR, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("mem fill 3", OP_MEM, 30'h0000103, 4'h0, 1'b0, 2'd1, 0);
    add_step("fwd older", OP_STORE, 30'h0002000, 4'b0011, 1'b0, 2'd0, 0);
    add_step("fwd younger", OP_STORE, 30'h0002000, 4'b0110, 1'b0, 2'd0, 0);
    add_step("fwd other word", OP_STORE, 30'h0002001, 4'b1111, 1'b0, 2'd0, 0);
    add_step("fwd fourth word", OP_STORE, 30'h0002003, 4'h0, 1'b0, 2'd0, 0);
    add_step("fwd merge", OP_LOAD, 30'h0002000, 4'h0, 1'b0, 2'd0, 4'b0111);
    add_step("fwd full word", OP_LOAD, 30'h0002001, 4'h0, 1'b0, 2'd0, 4'b1111);
    add_step("fwd no match", OP_LOAD, 30'h0002002, 4'h0, 1'b0, 2'd0, 0);
    add_step("full before flush", OP_READY, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("commit before flush", OP_COMMIT, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("flush misses", OP_FLUSH, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("fwd after flush", OP_LOAD, 30'h0002000, 4'h0, 1'b0, 2'd0, 0);
    add_step("ready after flush", OP_READY, 30'h0, 4'h0, 1'b0, 2'd0, 1);
    add_step("order a", OP_STORE, 30'h0000123, 4'hf, 1'b1, 2'd2, 0);
    add_step("order b", OP_STORE, 30'h0000456, 4'h0, 1'b1, 2'd3, 0);
    add_step("order c", OP_STORE, 30'h3fff789, 4'h0, 1'b1, 2'd0, 0);
    add_step("commit a", OP_COMMIT, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("drain a", OP_WAIT_WR, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("commit b", OP_COMMIT, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("drain b", OP_WAIT_WR, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("commit c", OP_COMMIT, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("drain c", OP_WAIT_WR, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("mem a", OP_MEM, 30'h0000123, 4'h0, 1'b0, 2'd2, 0);
    add_step("mem b", OP_MEM, 30'h0000456, 4'h0, 1'b0, 2'd3, 0);
    add_step("mem c", OP_MEM, 30'h3fff789, 4'h0, 1'b0, 2'd0, 0);
    add_step("miss store", OP_STORE, 30'h0000abc, 4'h0, 1'b0, 2'd0, 0);
    add_step("commit miss", OP_COMMIT, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("miss holds", OP_NO_WR, 30'h0, 4'h0, 1'b0, 2'd0, 10);
    add_step("refill", OP_SNOOP, 30'h0000abc, 4'h0, 1'b0, 2'd3, 0);
    add_step("drain after refill", OP_WAIT_WR, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("mem refill", OP_MEM, 30'h0000abc, 4'h0, 1'b0, 2'd3, 0);
    add_step("gate a", OP_STORE, 30'h0000300, 4'h0, 1'b1, 2'd1, 0);
    add_step("gate b", OP_STORE, 30'h0000304, 4'h0, 1'b1, 2'd2, 0);
    add_step("no commit no write", OP_NO_WR, 30'h0, 4'h0, 1'b0, 2'd0, 8);
    add_step("commit gate a", OP_COMMIT, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("drain gate a", OP_WAIT_WR, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("one write per commit", OP_NO_WR, 30'h0, 4'h0, 1'b0, 2'd0, 5);
    add_step("commit gate b", OP_COMMIT, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("drain gate b", OP_WAIT_WR, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("stale a", OP_STORE, 30'h0000500, 4'h0, 1'b1, 2'd1, 0);
    add_step("stale b", OP_STORE, 30'h0000501, 4'h0, 1'b1, 2'd1, 0);
    add_step("flush hits", OP_FLUSH, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("after flush", OP_STORE, 30'h0000600, 4'h0, 1'b1, 2'd1, 0);
    add_step("commit after flush", OP_COMMIT, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("drain after flush", OP_WAIT_WR, 30'h0, 4'h0, 1'b0, 2'd0, 0);
    add_step("mem after flush", OP_MEM, 30'h0000600, 4'h0, 1'b0, 2'd1, 0);
    add_step("stale not written", OP_MEM, 30'h0000500, 4'h0, 1'b0, 2'd1, 0);
    add_step("settle", OP_IDLE, 30'h0, 4'h0, 1'b0, 2'd0, 4);
  endfunction

  initial
  begin
    void'($urandom(32'h848113eb));
    credit   = 0;
    cur_step = "reset";
    // fill pattern built from the whole sram address
    for (int k = 0; k < 4096; k++)
    begin
      shadow_mem[k] = {k[11:0], ~k[11:0], 8'h5a};
      dut_mem[k]    = {k[11:0], ~k[11:0], 8'h5a};
    end
    rst_n_i    <= 1'b0;
    flush_i    <= 1'b0;
    st_valid_i <= 1'b0;
    st_meta_i  <= '0;
    commit_i   <= 1'b0;
    snoop_i    <= '0;
    ld_addr_i  <= '0;
    build_table();
    repeat (8) @(posedge clk);
    rst_n_i <= 1'b1;
    foreach (steps[i])
    begin
      run_step(steps[i]);
    end
    check_value("bound assertions", 0, dut_i.u_sb.u_assert.fail_cnt);
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- wired_lsu_sb_top.f
design/wired_sb_pkg.sv
design/wired_lsu_sb_entry.sv
design/wired_lsu_sb.sv
design/wired_lsu_sb_fwd.sv
design/wired_lsu_sb_drain.sv
design/wired_lsu_sb_top.sv
tests/wired_lsu_sb_assert.sv
tests/wired_lsu_sb_tb.sv
